//--- design/dbg_consts.svh
`ifndef DBG_CONSTS_SVH
`define DBG_CONSTS_SVH

// Word and address widths.
`define DBG_WORD_W        32         // Instruction word.
`define DBG_ADDR_W        8          // Program memory address.
`define DBG_MEM_DEPTH     256        // Words in program memory.

// Serial bit timing, in clocks per bit.
`define DBG_CLKS_PER_BIT  16         // Short for simulation.

// Memory operation kinds, decode to execute.
`define DBG_OP_WRITE      2'd0
`define DBG_OP_READ       2'd1
`define DBG_OP_ERASE      2'd2
`define DBG_OP_BAD        2'd3

// Host command bytes.
`define DBG_CMD_LOAD      8'h01      // Four data bytes follow, MSB first.
`define DBG_CMD_READ      8'h02      // One address byte follows.
`define DBG_CMD_ERASE     8'h03      // Soft reset.

// Response bytes.
`define DBG_RESP_ERASED   8'hA5
`define DBG_RESP_HALT     8'h48
`define DBG_RESP_BAD      8'hEE

`define DBG_HALT_OPCODE   6'd0       // Opcode field of the HALT instruction.

`endif

//--- design/dbg_pkg.sv
`default_nettype none
`include "dbg_consts.svh"

package dbg_pkg;

    ////////////////////
    // Serial side.
    ////////////////////

    typedef logic [7:0] byte_t;                        // One UART byte.

    ////////////////////
    // Memory side.
    ////////////////////

    typedef logic [`DBG_WORD_W-1:0] word_t;            // Instruction word.
    typedef logic [`DBG_ADDR_W-1:0] addr_t;            // Program memory address.

    // Kind of memory operation, one of the DBG_OP codes.
    typedef logic [1:0] op_t;

    // Bits 31:26 of an instruction.
    typedef logic [5:0] opcode_t;

endpackage

`default_nettype wire

//--- design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_consts.svh"

module uart_rx (
    input  logic           i_clock,
    input  logic           i_arst_n,
    input  logic           i_rx,               // Serial line from host.
    output logic           o_rx_valid,         // One-cycle pulse per good byte.
    output dbg_pkg::byte_t o_rx_data
);
    import dbg_pkg::*;

    localparam int CNT_W = $clog2(`DBG_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`DBG_CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`DBG_CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state_q;
    logic             rx_meta_q;               // Synchronizer, first stage.
    logic             rx_sync_q;               // Synchronizer, second stage.
    logic [CNT_W-1:0] cnt_q;                   // Clocks within the bit.
    logic [2:0]       bit_q;                   // Data bit index.
    byte_t            shift_q;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_meta_q  <= 1'b1;                // Line rests high.
            rx_sync_q  <= 1'b1;
            state_q    <= RX_IDLE;
            cnt_q      <= '0;
            bit_q      <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            rx_meta_q  <= i_rx;
            rx_sync_q  <= rx_meta_q;
            o_rx_valid <= 1'b0;
            cnt_q      <= cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rx_sync_q) state_q <= RX_START;   // Falling edge.
                end
                RX_START: if (cnt_q == HALF_LAST) begin
                    cnt_q   <= '0;
                    // Glitch check at half a bit.
                    state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (cnt_q == BIT_LAST) begin
                    cnt_q <= '0;
                    bit_q <= bit_q + 1'b1;     // Wraps to 0 after bit 7.
                    if (bit_q == 3'd7) state_q <= RX_STOP;
                end
                RX_STOP: if (cnt_q == BIT_LAST) begin
                    o_rx_valid <= rx_sync_q;   // Low stop bit is a framing error.
                    state_q    <= RX_IDLE;
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Mid-bit sampling, LSB first.
    always_ff @(posedge i_clock) begin
        if (state_q == RX_DATA && cnt_q == BIT_LAST) shift_q <= {rx_sync_q, shift_q[7:1]};
    end

    assign o_rx_data = shift_q;

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_consts.svh"

module uart_tx (
    input  logic           i_clock,
    input  logic           i_arst_n,
    input  logic           i_tx_valid,
    output logic           o_tx_ready,         // High while idle.
    input  dbg_pkg::byte_t i_tx_data,
    output logic           o_tx                // Serial line to host.
);
    import dbg_pkg::*;

    localparam int CNT_W = $clog2(`DBG_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`DBG_CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e        state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_q;
    byte_t            shift_q;                 // Bits still to send, LSB next.
    logic             bit_end;
    logic             load;
    logic             shift;

    assign o_tx_ready = (state_q == TX_IDLE);
    assign load       = i_tx_valid && o_tx_ready;
    assign bit_end    = (cnt_q == BIT_LAST);
    // Next data bit leaves the register at the end of start and of bits 0 to 6.
    assign shift      = bit_end && (state_q == TX_START || (state_q == TX_DATA && bit_q != 3'd7));

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            o_tx    <= 1'b1;
        end else begin
            cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            if (shift) o_tx <= shift_q[0];
            case (state_q)
                TX_IDLE: begin
                    cnt_q <= '0;
                    if (load) begin
                        state_q <= TX_START;
                        o_tx    <= 1'b0;       // Start bit.
                    end
                end
                TX_START: if (bit_end) state_q <= TX_DATA;
                TX_DATA: if (bit_end) begin
                    bit_q <= bit_q + 1'b1;
                    if (bit_q == 3'd7) begin
                        state_q <= TX_STOP;
                        o_tx    <= 1'b1;       // Stop bit.
                    end
                end
                TX_STOP: if (bit_end) state_q <= TX_IDLE;
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (load) shift_q <= i_tx_data;
        else if (shift) shift_q <= {1'b0, shift_q[7:1]};
    end

endmodule

`default_nettype wire

//--- design/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_consts.svh"

module cmd_decode (
    input  logic           i_clock,
    input  logic           i_arst_n,
    input  logic           i_rx_valid,         // No ready, a UART cannot stall.
    input  dbg_pkg::byte_t i_rx_data,
    output logic           o_op_valid,
    input  logic           i_op_ready,
    output dbg_pkg::op_t   o_op_kind,
    output dbg_pkg::addr_t o_op_addr,          // READ only.
    output dbg_pkg::word_t o_op_data           // WRITE only.
);
    import dbg_pkg::*;

    typedef enum logic [1:0] {DEC_IDLE, DEC_LOAD, DEC_READ, DEC_OP} dec_state_e;

    dec_state_e state_q;
    logic [1:0] byte_cnt_q;                    // LOAD data bytes received.
    op_t        kind_q;
    addr_t      addr_q;
    word_t      data_q;

    ////////////////////
    // Command FSM.
    ////////////////////

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= DEC_IDLE;
            byte_cnt_q <= '0;
            kind_q     <= `DBG_OP_BAD;
        end else begin
            case (state_q)
                DEC_IDLE: if (i_rx_valid) begin
                    byte_cnt_q <= '0;
                    case (i_rx_data)
                        `DBG_CMD_LOAD: state_q <= DEC_LOAD;
                        `DBG_CMD_READ: state_q <= DEC_READ;
                        `DBG_CMD_ERASE: begin
                            kind_q  <= `DBG_OP_ERASE;
                            state_q <= DEC_OP;
                        end
                        default: begin
                            kind_q  <= `DBG_OP_BAD;   // Unknown byte, op at once.
                            state_q <= DEC_OP;
                        end
                    endcase
                end
                DEC_LOAD: if (i_rx_valid) begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q == 2'd3) begin
                        kind_q  <= `DBG_OP_WRITE;
                        state_q <= DEC_OP;
                    end
                end
                DEC_READ: if (i_rx_valid) begin
                    kind_q  <= `DBG_OP_READ;
                    state_q <= DEC_OP;
                end
                DEC_OP: if (i_op_ready) state_q <= DEC_IDLE;   // Bytes here are dropped.
                default: state_q <= DEC_IDLE;
            endcase
        end
    end

    ////////////////////
    // Operand capture.
    ////////////////////

    always_ff @(posedge i_clock) begin
        // Word assembled MSB first.
        if (state_q == DEC_LOAD && i_rx_valid) data_q <= {data_q[`DBG_WORD_W-9:0], i_rx_data};
        if (state_q == DEC_READ && i_rx_valid) addr_q <= addr_t'(i_rx_data);
    end

    assign o_op_valid = (state_q == DEC_OP);
    assign o_op_kind  = kind_q;
    assign o_op_addr  = addr_q;
    assign o_op_data  = data_q;

endmodule

`default_nettype wire

//--- design/prog_mem_exec.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_consts.svh"

module prog_mem_exec (
    input  logic           i_clock,
    input  logic           i_arst_n,
    input  logic           i_op_valid,
    output logic           o_op_ready,         // Idle, no pending response.
    input  dbg_pkg::op_t   i_op_kind,
    input  dbg_pkg::addr_t i_op_addr,
    input  dbg_pkg::word_t i_op_data,
    output logic           o_rsp_valid,
    input  logic           i_rsp_ready,
    output dbg_pkg::word_t o_rsp_word,
    output logic           o_rsp_four          // Four bytes, else one in bits 7:0.
);
    import dbg_pkg::*;

    localparam logic [`DBG_ADDR_W:0] ERASE_END = (`DBG_ADDR_W + 1)'(`DBG_MEM_DEPTH);

    typedef enum logic [1:0] {EX_IDLE, EX_READ, EX_ERASE, EX_RESP} exec_state_e;

    exec_state_e           state_q;
    addr_t                 ptr_q;              // Next load address.
    logic                  lock_q;             // HALT seen, LOADs refused.
    logic [`DBG_ADDR_W:0]  erase_cnt_q;        // Extra bit marks the end.
    word_t                 mem [`DBG_MEM_DEPTH];
    word_t                 rd_q;               // Synchronous read port.
    word_t                 rsp_q;
    logic                  four_q;
    logic                  accept;
    logic                  erasing;
    logic                  mem_we;
    logic                  mem_re;
    addr_t                 mem_waddr;
    word_t                 mem_wdata;
    opcode_t               opcode;
    logic                  is_halt;

    assign o_op_ready = (state_q == EX_IDLE);
    assign accept     = i_op_valid && o_op_ready;
    assign opcode     = i_op_data[`DBG_WORD_W-1 -: 6];
    assign is_halt    = (opcode == `DBG_HALT_OPCODE);
    assign erasing    = (state_q == EX_ERASE) && !erase_cnt_q[`DBG_ADDR_W];

    // One write port, shared by LOAD and the erase sweep.
    assign mem_we    = erasing || (accept && i_op_kind == `DBG_OP_WRITE && !lock_q);
    assign mem_waddr = erasing ? erase_cnt_q[`DBG_ADDR_W-1:0] : ptr_q;
    assign mem_wdata = erasing ? '0 : i_op_data;
    assign mem_re    = accept && (i_op_kind == `DBG_OP_READ);

    always_ff @(posedge i_clock) begin
        if (mem_we) mem[mem_waddr] <= mem_wdata;
        if (mem_re) rd_q <= mem[i_op_addr];
    end

    ////////////////////
    // Control.
    ////////////////////

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= EX_IDLE;
            ptr_q       <= '0;
            lock_q      <= 1'b0;
            erase_cnt_q <= '0;
        end else begin
            case (state_q)
                EX_IDLE: if (accept) begin
                    case (i_op_kind)
                        `DBG_OP_WRITE: begin
                            if (!lock_q) begin
                                ptr_q  <= ptr_q + 1'b1;
                                lock_q <= is_halt;
                            end
                            state_q <= EX_RESP;
                        end
                        `DBG_OP_READ: state_q <= EX_READ;    // Wait for the read port.
                        `DBG_OP_ERASE: begin
                            ptr_q       <= '0;
                            lock_q      <= 1'b0;
                            erase_cnt_q <= '0;
                            state_q     <= EX_ERASE;
                        end
                        default: state_q <= EX_RESP;
                    endcase
                end
                EX_READ: state_q <= EX_RESP;
                EX_ERASE: begin
                    erase_cnt_q <= erase_cnt_q + 1'b1;
                    if (erase_cnt_q == ERASE_END) state_q <= EX_RESP;   // All words cleared.
                end
                EX_RESP: if (i_rsp_ready) state_q <= EX_IDLE;
                default: state_q <= EX_IDLE;
            endcase
        end
    end

    // Response payload.
    always_ff @(posedge i_clock) begin
        if (accept) begin
            four_q <= (i_op_kind == `DBG_OP_READ);
            case (i_op_kind)
                `DBG_OP_WRITE: begin
                    if (lock_q) rsp_q <= word_t'(`DBG_RESP_BAD);
                    else if (is_halt) rsp_q <= word_t'(`DBG_RESP_HALT);
                    else rsp_q <= word_t'(ptr_q);                 // Address written.
                end
                `DBG_OP_ERASE: rsp_q <= word_t'(`DBG_RESP_ERASED);
                `DBG_OP_BAD: rsp_q <= word_t'(`DBG_RESP_BAD);
                default: ;                                        // READ fills in later.
            endcase
        end else if (state_q == EX_READ) begin
            rsp_q <= rd_q;
        end
    end

    assign o_rsp_valid = (state_q == EX_RESP);
    assign o_rsp_word  = rsp_q;
    assign o_rsp_four  = four_q;

endmodule

`default_nettype wire

//--- design/resp_serializer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_consts.svh"

module resp_serializer (
    input  logic           i_clock,
    input  logic           i_arst_n,
    input  logic           i_rsp_valid,
    output logic           o_rsp_ready,        // Idle only.
    input  dbg_pkg::word_t i_rsp_word,
    input  logic           i_rsp_four,
    output logic           o_tx_valid,
    input  logic           i_tx_ready,
    output dbg_pkg::byte_t o_tx_data
);
    import dbg_pkg::*;

    typedef enum logic {SER_IDLE, SER_SEND} ser_state_e;

    ser_state_e state_q;
    logic [1:0] left_q;                        // Bytes after the current one.
    word_t      word_q;                        // Current byte in the top bits.
    logic       capture;
    logic       sent;

    assign o_rsp_ready = (state_q == SER_IDLE);
    assign o_tx_valid  = (state_q == SER_SEND);
    assign capture     = i_rsp_valid && o_rsp_ready;
    assign sent        = o_tx_valid && i_tx_ready;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= SER_IDLE;
            left_q  <= '0;
        end else if (capture) begin
            state_q <= SER_SEND;
            left_q  <= i_rsp_four ? 2'd3 : 2'd0;
        end else if (sent) begin
            if (left_q == 2'd0) state_q <= SER_IDLE;   // Last byte gone.
            left_q <= left_q - 1'b1;
        end
    end

    always_ff @(posedge i_clock) begin
        // One-byte response moved up so the top byte always leaves next.
        if (capture) word_q <= i_rsp_four ? i_rsp_word : {i_rsp_word[7:0], 24'b0};
        else if (sent) word_q <= {word_q[`DBG_WORD_W-9:0], 8'b0};
    end

    assign o_tx_data = word_q[`DBG_WORD_W-1 -: 8];   // MSB first.

endmodule

`default_nettype wire

//--- design/dbg_top.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_top (
    input  logic i_clock,
    input  logic i_arst_n,
    input  logic i_uart_rx,                    // From host.
    output logic o_uart_tx                     // To host.
);
    import dbg_pkg::*;

    logic  rx_valid;
    byte_t rx_data;
    logic  op_valid;
    logic  op_ready;
    op_t   op_kind;
    addr_t op_addr;
    word_t op_data;
    logic  rsp_valid;
    logic  rsp_ready;
    word_t rsp_word;
    logic  rsp_four;
    logic  tx_valid;
    logic  tx_ready;
    byte_t tx_data;

    uart_rx u_uart_rx (
        .i_clock (i_clock), .i_arst_n (i_arst_n), .i_rx (i_uart_rx),
        .o_rx_valid (rx_valid), .o_rx_data (rx_data)
    );

    // Decode stage.
    cmd_decode u_cmd_decode (
        .i_clock (i_clock), .i_arst_n (i_arst_n),
        .i_rx_valid (rx_valid), .i_rx_data (rx_data),
        .o_op_valid (op_valid), .i_op_ready (op_ready), .o_op_kind (op_kind),
        .o_op_addr (op_addr), .o_op_data (op_data)
    );

    // Execute stage.
    prog_mem_exec u_prog_mem_exec (
        .i_clock (i_clock), .i_arst_n (i_arst_n),
        .i_op_valid (op_valid), .o_op_ready (op_ready), .i_op_kind (op_kind),
        .i_op_addr (op_addr), .i_op_data (op_data),
        .o_rsp_valid (rsp_valid), .i_rsp_ready (rsp_ready),
        .o_rsp_word (rsp_word), .o_rsp_four (rsp_four)
    );

    // Result stage.
    resp_serializer u_resp_serializer (
        .i_clock (i_clock), .i_arst_n (i_arst_n),
        .i_rsp_valid (rsp_valid), .o_rsp_ready (rsp_ready),
        .i_rsp_word (rsp_word), .i_rsp_four (rsp_four),
        .o_tx_valid (tx_valid), .i_tx_ready (tx_ready), .o_tx_data (tx_data)
    );

    uart_tx u_uart_tx (
        .i_clock (i_clock), .i_arst_n (i_arst_n),
        .i_tx_valid (tx_valid), .o_tx_ready (tx_ready), .i_tx_data (tx_data),
        .o_tx (o_uart_tx)
    );

endmodule

`default_nettype wire

//--- testbench/dbg_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_consts.svh"

module dbg_properties #(
    parameter int PAYLOAD_W = 8
) (
    input logic                 i_clock,
    input logic                 i_arst_n,
    input logic                 i_valid,       // Offer side of a valid/ready pair.
    input logic                 i_ready,
    input logic [PAYLOAD_W-1:0] i_payload,     // Fields that ride with valid.
    input logic                 i_sweep_start, // Erase op handed over.
    input logic                 i_sweep_quiet  // Must stay low through the sweep.
);

    // Acceptance to response of an erase.
    localparam logic [`DBG_ADDR_W:0] SWEEP_CYCLES = (`DBG_ADDR_W + 1)'(`DBG_MEM_DEPTH + 1);

    logic [`DBG_ADDR_W:0] sweep_left_q;        // Sweep cycles still to come.
    int unsigned          fail_count = 0;      // Failed assertions so far.

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            sweep_left_q <= '0;
        end else if (i_sweep_start) begin
            sweep_left_q <= SWEEP_CYCLES;
        end else if (sweep_left_q != '0) begin
            sweep_left_q <= sweep_left_q - 1'b1;
        end
    end

    // An offer not taken stays up with its fields unchanged.
    hold_until_ready: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_valid && !i_ready |=> i_valid && (i_payload === $past(i_payload)))
        else begin
            $error("valid dropped or its fields changed before ready");
            fail_count++;
        end

    // Nothing moves while the sweep owns the write port.
    quiet_in_sweep: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        sweep_left_q != '0 |-> !i_sweep_quiet)
        else begin
            $error("handshake signal high during the erase sweep");
            fail_count++;
        end

endmodule

////////////////////
// Decode to execute.
////////////////////
bind cmd_decode dbg_properties #(.PAYLOAD_W(2 + `DBG_ADDR_W + `DBG_WORD_W)) u_op_props (
    .i_clock (i_clock), .i_arst_n (i_arst_n),
    .i_valid (o_op_valid), .i_ready (i_op_ready),
    .i_payload ({o_op_kind, o_op_addr, o_op_data}),
    .i_sweep_start (o_op_valid && i_op_ready && o_op_kind == `DBG_OP_ERASE),
    .i_sweep_quiet (i_op_ready)
);

////////////////////
// Execute to result.
////////////////////
bind prog_mem_exec dbg_properties #(.PAYLOAD_W(1 + `DBG_WORD_W)) u_rsp_props (
    .i_clock (i_clock), .i_arst_n (i_arst_n),
    .i_valid (o_rsp_valid), .i_ready (i_rsp_ready),
    .i_payload ({o_rsp_four, o_rsp_word}),
    .i_sweep_start (i_op_valid && o_op_ready && i_op_kind == `DBG_OP_ERASE),
    .i_sweep_quiet (o_rsp_valid)
);

`default_nettype wire

//--- testbench/dbg_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dbg_consts.svh"

module dbg_tb;
    import dbg_pkg::*;

    localparam int BIT_CLKS     = `DBG_CLKS_PER_BIT;
    localparam int RESP_TIMEOUT = 4000;        // Clocks to wait for a response.

    logic        i_clock = 1'b0;
    logic        i_arst_n;
    logic        i_uart_rx;
    logic        o_uart_tx;
    int unsigned errors;
    int unsigned timeouts;
    int unsigned assert_fails;                 // Failures of the bound checkers.
    word_t       shadow_mem [`DBG_MEM_DEPTH];  // Expected memory contents.
    addr_t       shadow_ptr;                   // Expected load address.
    logic        shadow_lock;                  // Expected HALT lock.

    dbg_top u_dbg_top (
        .i_clock (i_clock), .i_arst_n (i_arst_n),
        .i_uart_rx (i_uart_rx), .o_uart_tx (o_uart_tx)
    );

    always #2 i_clock = ~i_clock;              // 4 ns period.

    ////////////////////
    // Host model.
    ////////////////////

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};               // Stop, data, start.
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clock);
            i_uart_rx <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge i_clock);
        end
    endtask

    // Line watched on falling edges away from DUT updates.
    task automatic recv_byte(output byte_t b, output logic ok);
        int unsigned waited;
        waited = 0;
        b      = '0;
        ok     = 1'b0;
        do begin
            @(negedge i_clock);
            waited++;
        end while (o_uart_tx !== 1'b0 && waited < RESP_TIMEOUT);
        if (o_uart_tx !== 1'b0) begin
            $display("Timed out after %0d clocks waiting for a start bit on o_uart_tx.", waited);
            timeouts++;
            return;
        end
        repeat (BIT_CLKS / 2) @(negedge i_clock);   // Middle of start bit.
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge i_clock);
            b[i] = o_uart_tx;                  // LSB first.
        end
        repeat (BIT_CLKS) @(negedge i_clock);
        if (o_uart_tx !== 1'b1) begin
            $display("Stop bit on o_uart_tx was low, response byte lost.");
            errors++;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic expect_byte(input byte_t exp, input string what);
        byte_t got;
        logic  ok;
        recv_byte(got, ok);
        if (ok) begin
            assert (got === exp) else begin
                $display("[FAIL] o_uart_tx %s: expected 0x%h, got 0x%h", what, exp, got);
                errors++;
            end
        end
    endtask

    function automatic word_t random_program_word();
        word_t w;
        w = $urandom;
        if (w[31:26] == `DBG_HALT_OPCODE) w[31:26] = 6'h23;   // lw instead.
        return w;
    endfunction

    ////////////////////
    // Commands.
    ////////////////////

    task automatic erase_cmd();
        send_byte(`DBG_CMD_ERASE);
        for (int a = 0; a < `DBG_MEM_DEPTH; a++) begin
            shadow_mem[a] = '0;
        end
        shadow_ptr  = '0;
        shadow_lock = 1'b0;
        expect_byte(`DBG_RESP_ERASED, "ERASE ack");
    endtask

    task automatic load_cmd(input word_t w);
        byte_t exp;
        send_byte(`DBG_CMD_LOAD);
        for (int i = 3; i >= 0; i--) send_byte(w[8*i +: 8]);   // MSB first.
        if (shadow_lock) begin
            exp = `DBG_RESP_BAD;               // Refused and nothing stored.
        end else begin
            exp = (w[31:26] == `DBG_HALT_OPCODE) ? `DBG_RESP_HALT : byte_t'(shadow_ptr);
            shadow_lock            = (w[31:26] == `DBG_HALT_OPCODE);
            shadow_mem[shadow_ptr] = w;
            shadow_ptr             = shadow_ptr + 1'b1;
        end
        expect_byte(exp, "LOAD ack");
    endtask

    task automatic read_cmd(input addr_t a);
        word_t exp;
        exp = shadow_mem[a];
        send_byte(`DBG_CMD_READ);
        send_byte(byte_t'(a));
        for (int i = 3; i >= 0; i--) begin
            expect_byte(exp[8*i +: 8], $sformatf("READ 0x%h byte %0d", a, i));
        end
    endtask

    ////////////////////
    // Directed tests.
    ////////////////////

    task automatic test_erase_after_reset();
        erase_cmd();
        read_cmd(8'h00);
        read_cmd(8'h01);
        read_cmd(8'h7F);
        read_cmd(8'hFF);                       // Top of memory.
    endtask

    task automatic test_load_sequence();
        for (int i = 0; i < 6; i++) load_cmd(random_program_word());   // Acks 0 to 5.
        for (int i = 0; i < 6; i++) read_cmd(addr_t'(i));
    endtask

    task automatic test_halt_lock();
        word_t halt_word;
        addr_t halt_addr;
        halt_word        = $urandom;
        halt_word[31:26] = `DBG_HALT_OPCODE;
        halt_addr        = shadow_ptr;
        load_cmd(halt_word);                   // Ack 0x48 and lock set.
        load_cmd(random_program_word());       // Refused with 0xEE.
        read_cmd(halt_addr);
        read_cmd(halt_addr + 1'b1);            // Still the erased value.
    endtask

    task automatic test_erase_reload();
        erase_cmd();
        for (int i = 0; i < 8; i++) read_cmd(addr_t'(i));
        load_cmd(random_program_word());       // Pointer back at 0.
        read_cmd(8'h00);
    endtask

    task automatic test_bad_command();
        send_byte(8'h7F);
        expect_byte(`DBG_RESP_BAD, "unknown 0x7F ack");
        send_byte(8'hFF);
        expect_byte(`DBG_RESP_BAD, "unknown 0xFF ack");
        load_cmd(random_program_word());       // Normal service resumes.
        read_cmd(shadow_ptr - 1'b1);
    endtask

    initial begin
        void'($urandom(32'h38654304));
        errors      = 0;
        timeouts    = 0;
        shadow_ptr  = '0;
        shadow_lock = 1'b0;
        i_arst_n    = 1'b0;
        i_uart_rx   = 1'b1;                    // Idle line.
        repeat (5) @(posedge i_clock);
        i_arst_n <= 1'b1;
        repeat (2) @(posedge i_clock);
        test_erase_after_reset();
        test_load_sequence();
        test_halt_lock();
        test_erase_reload();
        test_bad_command();
        assert_fails = u_dbg_top.u_cmd_decode.u_op_props.fail_count
                     + u_dbg_top.u_prog_mem_exec.u_rsp_props.fail_count;
        $display("Closing report: %0d check errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dbg_loader.f
+incdir+design
design/dbg_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_decode.sv
design/prog_mem_exec.sv
design/resp_serializer.sv
design/dbg_top.sv
testbench/dbg_properties.sv
testbench/dbg_tb.sv

//--- Makefile
# Verilator build and run for dbg_loader.

VERILATOR ?= verilator
TOP       ?= dbg_tb
FILELIST  ?= dbg_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS
FAIL_MSG  ?= ERRORS FOUND

SRCS := $(wildcard design/*.sv design/*.svh testbench/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '$(FAIL_MSG)' $(LOG) || ! grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
